// File: design/etx_credit_tx.sv
`timescale 1ns/100ps
`default_nettype none

module etx_credit_tx #(
   parameter int LINK_CREDITS = etx_pkg::link_credits_default,
   parameter int SEQ_W        = etx_pkg::seq_w
) (
   input  wire                    sys_clk,
   input  wire                    sys_nreset,
   input  wire                    tx_nreset,
   input  wire                    tx_active,
   input  wire etx_pkg::etx_pkt_t rd_pkt,
   input  wire                    rd_empty,
   output logic                   rd_pop,
   input  wire                    lnk_credit,
   output logic                   lnk_valid,
   output etx_pkg::etx_pkt_t      lnk_pkt,
   output logic [SEQ_W-1:0]       lnk_seq
);

   localparam int CW = $clog2(LINK_CREDITS + 1);
   localparam logic [CW-1:0] CREDITS_FULL = CW'(LINK_CREDITS);

   logic [CW-1:0]    credit_cnt;
   logic [SEQ_W-1:0] seq_tag;
   logic             send;

   //##################################################
   // send decision
   //##################################################

   // one packet per cycle while credits last
   assign send   = tx_active & tx_nreset & ~rd_empty & (credit_cnt != '0);
   assign rd_pop = send;

   // link credits, spent per packet and returned by the far end
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         credit_cnt <= CREDITS_FULL;
      else if (!tx_nreset)
         credit_cnt <= CREDITS_FULL;
      else
      begin
         case ({send, lnk_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;  // both or neither
         endcase
      end
   end

   // sequence tag lets the far end spot a lost packet
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         seq_tag <= '0;
      else if (!tx_nreset)
         seq_tag <= '0;
      else if (send)
         seq_tag <= seq_tag + 1'b1;
   end

   //##################################################
   // link outputs
   //##################################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         lnk_valid <= 1'b0;
      else if (!tx_nreset)
         lnk_valid <= 1'b0;
      else
         lnk_valid <= send;   // one cycle after the pop
   end

   always_ff @(posedge sys_clk)
   begin
      if (send)
      begin
         lnk_pkt <= rd_pkt;
         lnk_seq <= seq_tag;
      end
   end

endmodule

`default_nettype wire

// File: design/etx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module etx_fifo #(
   parameter int DEPTH = etx_pkg::fifo_depth_default
) (
   input  wire                    sys_clk,
   input  wire                    sys_nreset,
   input  wire                    tx_nreset,
   input  wire                    wr_en,
   input  wire etx_pkg::etx_pkt_t wr_pkt,
   input  wire                    rd_pop,
   output etx_pkg::etx_pkt_t      rd_pkt,
   output logic                   rd_empty,
   output logic                   slot_freed
);

   localparam int AW   = $clog2(DEPTH);
   localparam int CNTW = $clog2(DEPTH + 1);
   localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

   etx_pkg::etx_pkt_t mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic [CNTW-1:0]   count;       // occupancy
   logic              pop;

   assign pop = rd_pop & ~rd_empty;

   // storage, no full check since the host holds a credit per slot
   always_ff @(posedge sys_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_pkt;
   end

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         slot_freed <= 1'b0;
      end
      else if (!tx_nreset)
      begin
         wr_ptr     <= '0;   // flush while link is down
         rd_ptr     <= '0;
         count      <= '0;
         slot_freed <= 1'b0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         slot_freed <= pop;  // credit back to host
      end
   end

   assign rd_empty = (count == '0);
   assign rd_pkt   = mem[rd_ptr];   // head of queue

endmodule

`default_nettype wire

// File: design/etx_pkg.sv
`default_nettype none

package etx_pkg;

   //##################################################
   // link packet
   //##################################################

   typedef struct packed {
      logic        write;   // 1 = write, 0 = read request
      logic [31:0] addr;
      logic [31:0] data;
   } etx_pkt_t;             // 65 bits

   //##################################################
   // startup sequencer
   //##################################################

   typedef enum logic [2:0] {
      reset_all    = 3'b000,  // everything held
      start_pll    = 3'b001,  // pll running, waiting for lock
      stop_pll     = 3'b010,
      release_chip = 3'b011,  // remote chip out of reset
      hold         = 3'b100,
      active       = 3'b101   // transmit path open
   } etx_state_e;

   // link sequence tag
   localparam int seq_w = 8;

   // defaults for the top level parameters
   localparam int rcw_default          = 4;  // heartbeat counter width
   localparam int fifo_depth_default   = 8;
   localparam int link_credits_default = 4;

endpackage

`default_nettype wire

// File: design/etx_reset_seq.sv
`timescale 1ns/100ps
`default_nettype none

module etx_reset_seq #(
   parameter int RCW = etx_pkg::rcw_default
) (
   input  wire  sys_clk,
   input  wire  sys_nreset,
   input  wire  soft_reset,
   input  wire  pll_locked,
   output logic pll_reset,
   output logic chip_nreset,
   output logic tx_active,
   output logic tx_nreset
);

   logic [RCW-1:0]      hb_cnt;
   logic                heartbeat;
   logic                lock_meta;
   logic                lock_sync;
   logic [1:0]          nrst_pipe;
   etx_pkg::etx_state_e state;

   //##################################################
   // heartbeat
   //##################################################

   // free-running, wraps every 2**RCW cycles
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         hb_cnt <= '0;
      else
         hb_cnt <= hb_cnt + 1'b1;
   end

   assign heartbeat = &hb_cnt;   // one cycle per wrap

   // pll lock comes from another clock, two flops
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //##################################################
   // startup state machine
   //##################################################

   // at most one step per heartbeat
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         state <= etx_pkg::reset_all;
      else if (heartbeat)
      begin
         case (state)
            etx_pkg::reset_all:
               if (!soft_reset)
                  state <= etx_pkg::start_pll;
            etx_pkg::start_pll:
               if (lock_sync)
                  state <= etx_pkg::stop_pll;
            etx_pkg::stop_pll:
               state <= etx_pkg::release_chip;
            etx_pkg::release_chip:
               state <= etx_pkg::hold;
            etx_pkg::hold:
               if (lock_sync)
                  state <= etx_pkg::active;
            etx_pkg::active:
               if (soft_reset)
                  state <= etx_pkg::reset_all;  // full restart
            default:
               state <= etx_pkg::reset_all;
         endcase
      end
   end

   // output decode
   assign pll_reset   = (state == etx_pkg::reset_all) ||
                        (state == etx_pkg::stop_pll)  ||
                        (state == etx_pkg::release_chip);

   assign chip_nreset = (state == etx_pkg::release_chip) ||
                        (state == etx_pkg::hold)         ||
                        (state == etx_pkg::active);

   assign tx_active   = (state == etx_pkg::active);

   // datapath reset trails tx_active by two cycles
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         nrst_pipe <= 2'b00;
      else
         nrst_pipe <= {nrst_pipe[0], tx_active};
   end

   assign tx_nreset = nrst_pipe[1];

endmodule

`default_nettype wire

// File: design/etx_top.sv
`timescale 1ns/100ps
`default_nettype none

module etx_top #(
   parameter int RCW          = etx_pkg::rcw_default,
   parameter int FIFO_DEPTH   = etx_pkg::fifo_depth_default,
   parameter int LINK_CREDITS = etx_pkg::link_credits_default
) (
   input  wire                      sys_clk,
   input  wire                      sys_nreset,
   // control
   input  wire                      soft_reset,
   input  wire                      pll_locked,
   output logic                     pll_reset,
   output logic                     chip_nreset,
   output logic                     tx_active,
   // host side
   input  wire                      host_valid,
   input  wire etx_pkg::etx_pkt_t   host_pkt,
   output logic                     host_credit,
   // link side
   output logic                     lnk_valid,
   output etx_pkg::etx_pkt_t        lnk_pkt,
   output logic [etx_pkg::seq_w-1:0] lnk_seq,
   input  wire                      lnk_credit
);

   logic              tx_nreset;   // datapath reset from sequencer
   etx_pkg::etx_pkt_t rd_pkt;
   logic              rd_empty;
   logic              rd_pop;

   etx_reset_seq #(
      .RCW (RCW)
   ) u_reset_seq (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .soft_reset  (soft_reset),
      .pll_locked  (pll_locked),
      .pll_reset   (pll_reset),
      .chip_nreset (chip_nreset),
      .tx_active   (tx_active),
      .tx_nreset   (tx_nreset)
   );

   etx_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .sys_clk    (sys_clk),
      .sys_nreset (sys_nreset),
      .tx_nreset  (tx_nreset),
      .wr_en      (host_valid),
      .wr_pkt     (host_pkt),
      .rd_pop     (rd_pop),
      .rd_pkt     (rd_pkt),
      .rd_empty   (rd_empty),
      .slot_freed (host_credit)
   );

   etx_credit_tx #(
      .LINK_CREDITS (LINK_CREDITS),
      .SEQ_W        (etx_pkg::seq_w)
   ) u_credit_tx (
      .sys_clk    (sys_clk),
      .sys_nreset (sys_nreset),
      .tx_nreset  (tx_nreset),
      .tx_active  (tx_active),
      .rd_pkt     (rd_pkt),
      .rd_empty   (rd_empty),
      .rd_pop     (rd_pop),
      .lnk_credit (lnk_credit),
      .lnk_valid  (lnk_valid),
      .lnk_pkt    (lnk_pkt),
      .lnk_seq    (lnk_seq)
   );

endmodule

`default_nettype wire

// File: tb.f
design/etx_pkg.sv
design/etx_reset_seq.sv
design/etx_fifo.sv
design/etx_credit_tx.sv
design/etx_top.sv
verif/etx_tb_assertions.sv
verif/etx_tb.sv

// File: verif/etx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module etx_tb;

   localparam int RCW          = 4;
   localparam int FIFO_DEPTH   = etx_pkg::fifo_depth_default;
   localparam int LINK_CREDITS = etx_pkg::link_credits_default;
   localparam int CLK_PERIOD   = 8;
   localparam int NUM_TESTS    = 5;
   localparam int HB           = 1 << RCW;   // cycles per heartbeat
   localparam int WATCHDOG_NS  = NUM_TESTS * 200 * HB * CLK_PERIOD;

   logic                      sys_clk = 1'b0;
   logic                      sys_nreset;
   logic                      soft_reset;
   logic                      pll_locked;
   logic                      pll_reset;
   logic                      chip_nreset;
   logic                      tx_active;
   logic                      host_valid;
   etx_pkg::etx_pkt_t         host_pkt;
   logic                      host_credit;
   logic                      lnk_valid;
   etx_pkg::etx_pkt_t         lnk_pkt;
   logic [etx_pkg::seq_w-1:0] lnk_seq;
   logic                      lnk_credit;

   etx_pkg::etx_pkt_t         exp_q[$];   // pushed, not yet on the link
   etx_pkg::etx_pkt_t         exp_pkt;
   logic [etx_pkg::seq_w-1:0] exp_tag;
   logic [etx_pkg::seq_w-1:0] exp_seq;
   logic                      withhold = 1'b0;   // far end keeps its credits
   int                        cyc;
   int                        err_cnt;
   int                        err_at;
   int                        fail_tests;
   int                        test_num;
   int                        seen;        // packets seen on the link
   int                        pushed;
   int                        push_left;
   int                        host_cred;
   int                        act_wait;
   int                        owed;        // credits the far end still owes
   int                        lock_dly;
   int                        lock_cyc;
   int                        base;

   etx_top #(
      .RCW          (RCW),
      .FIFO_DEPTH   (FIFO_DEPTH),
      .LINK_CREDITS (LINK_CREDITS)
   ) u_etx_top (.*);

   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   always @(posedge sys_clk)
   begin
      cyc <= cyc + 1;
   end

   //##################################################
   // models
   //##################################################

   // pll locks 20 to 60 cycles after its reset falls
   always @(negedge sys_clk)
   begin
      if (pll_reset !== 1'b0)
      begin
         pll_locked = 1'b0;
         lock_dly   = 20 + $urandom % 41;
      end
      else if (lock_dly > 0)
         lock_dly--;
      else if (!pll_locked)
      begin
         pll_locked = 1'b1;
         lock_cyc   = cyc;
      end
   end

   // host, one push per credit
   always @(negedge sys_clk)
   begin
      host_valid = 1'b0;
      if (host_credit)
         host_cred++;
      act_wait = tx_active ? act_wait + 1 : 0;
      if (act_wait == 1)
         host_cred = FIFO_DEPTH;   // fresh credits on each start
      if (push_left > 0 && host_cred > 0 && act_wait > 3 && $urandom % 4 != 0)
      begin
         host_pkt   = {1'($urandom), $urandom, $urandom};
         host_valid = 1'b1;
         host_cred--;
         push_left--;
         pushed++;
         exp_q.push_back(host_pkt);
      end
   end

   // far end returns credits after a random delay
   always @(negedge sys_clk)
   begin
      lnk_credit = 1'b0;
      if (!tx_active)
         owed = 0;
      else
      begin
         if (lnk_valid)
            owed++;
         if (!withhold && owed > 0 && $urandom % 3 == 0)
         begin
            lnk_credit = 1'b1;
            owed--;
         end
      end
   end

   //##################################################
   // reference and compare
   //##################################################

   function automatic etx_pkg::etx_pkt_t etx_expect(output logic [etx_pkg::seq_w-1:0] tag);
      etx_pkg::etx_pkt_t pkt;
      pkt     = exp_q.pop_front();
      tag     = exp_tag;
      exp_tag = exp_tag + 1'b1;   // one tag per packet, in order
      return pkt;
   endfunction

   task automatic report_err(input string msg);
      err_cnt++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   // compare errors plus failed assertions
   function automatic int total_errors();
      return err_cnt + u_etx_top.u_reset_seq.u_seq_assertions.fail_cnt +
             u_etx_top.u_credit_tx.u_tx_assertions.fail_cnt;
   endfunction

   always @(negedge sys_clk)
   begin
      if (lnk_valid === 1'b1)
      begin
         seen++;
         if (exp_q.size() == 0)
            report_err("packet on the link that was never pushed");
         else
         begin
            exp_pkt = etx_expect(exp_seq);
            if (lnk_pkt !== exp_pkt)
               report_err($sformatf("lnk_pkt %h, expected %h", lnk_pkt, exp_pkt));
            if (lnk_seq !== exp_seq)
               report_err($sformatf("lnk_seq %0d, expected %0d", lnk_seq, exp_seq));
         end
      end
   end

   //##################################################
   // test steps
   //##################################################

   task automatic end_test(input string name);
      int errs;
      errs = total_errors();
      test_num++;
      if (errs != err_at)
         fail_tests++;
      $display("test %0d %-16s %s", test_num, name, (errs == err_at) ? "ok" : "FAILED");
      err_at = errs;
   endtask

   task automatic check_startup();
      int t_pll;
      int t_chip;
      int t_act;
      while (pll_reset)
         @(negedge sys_clk);
      t_pll = cyc;
      if (chip_nreset !== 1'b0 || tx_active !== 1'b0)
         report_err("chip_nreset or tx_active up before pll_reset fell");
      while (!chip_nreset)
         @(negedge sys_clk);
      t_chip = cyc;
      if (tx_active !== 1'b0)
         report_err("tx_active up before chip_nreset");
      while (!tx_active)
         @(negedge sys_clk);
      t_act = cyc;
      if ((t_chip - t_pll) % HB != 0 || (t_act - t_chip) % HB != 0)
         report_err($sformatf("steps off heartbeat at %0d %0d %0d", t_pll, t_chip, t_act));
      if (pll_locked !== 1'b1 || lock_cyc >= t_act)
         report_err("tx_active rose before pll_locked");
   endtask

   task automatic wait_drained();
      while (push_left > 0 || exp_q.size() > 0 || owed > 0)
         @(negedge sys_clk);
      repeat (2) @(negedge sys_clk);
   endtask

   // link credits held back, then released
   task automatic stall_test(input int n, input int exp_push);
      int seen0;
      int push0;
      seen0     = seen;
      push0     = pushed;
      withhold  = 1'b1;
      push_left = n;
      repeat (150) @(negedge sys_clk);
      if (seen - seen0 != LINK_CREDITS)
         report_err($sformatf("%0d packets sent without returns", seen - seen0));
      if (pushed - push0 != exp_push)
         report_err($sformatf("host pushed %0d before stalling", pushed - push0));
      withhold = 1'b0;
      wait_drained();
      if (seen - seen0 != n)
         report_err($sformatf("%0d of %0d packets delivered", seen - seen0, n));
   endtask

   initial
   begin
      void'($urandom(32'hfb1e));
      sys_nreset = 1'b0;
      soft_reset = 1'b1;
      pll_locked = 1'b0;
      host_valid = 1'b0;
      host_pkt   = '0;
      lnk_credit = 1'b0;
      exp_tag    = '0;
      repeat (4) @(negedge sys_clk);
      sys_nreset = 1'b1;

      repeat (3 * HB)
      begin
         @(negedge sys_clk);
         if (pll_reset !== 1'b1 || chip_nreset !== 1'b0 || tx_active !== 1'b0 ||
             lnk_valid !== 1'b0 || host_credit !== 1'b0)
            report_err("outputs left their reset values under soft_reset");
      end
      end_test("reset values");

      soft_reset = 1'b0;
      check_startup();
      end_test("startup order");

      base      = seen;
      push_left = 40;
      wait_drained();
      if (seen - base != 40)
         report_err($sformatf("%0d of 40 packets delivered", seen - base));
      end_test("data transfer");

      stall_test(20, FIFO_DEPTH + LINK_CREDITS);
      end_test("credit limits");

      soft_reset = 1'b1;
      while (tx_active)
         @(negedge sys_clk);
      if (pll_reset !== 1'b1 || chip_nreset !== 1'b0)
         report_err("soft reset did not return the sequencer to reset_all");
      soft_reset = 1'b0;
      exp_tag    = '0;   // tags restart with the datapath
      check_startup();
      stall_test(6, 6);
      end_test("soft reset");

      $display("tests %0d, failed %0d, packets %0d, errors %0d",
               test_num, fail_tests, seen, total_errors());
      if (total_errors() == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run is stuck waiting", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/etx_tb_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module etx_tb_assertions #(
   parameter int LINK_CREDITS = etx_pkg::link_credits_default,
   parameter int CW           = 8,
   parameter bit SEQ_CHECKS   = 1'b1   // sequencer rules, else link rules
) (
   input wire          sys_clk,
   input wire          sys_nreset,
   input wire          pll_reset,
   input wire          chip_nreset,
   input wire          tx_active,
   input wire [CW-1:0] credit_cnt,
   input wire          rd_pop,
   input wire          rd_empty
);

   int fail_cnt = 0;   // failed assertions

   generate
      if (SEQ_CHECKS)
      begin : g_seq

         //##################################################
         // sequencer outputs
         //##################################################

         active_needs_chip: assert property (@(posedge sys_clk) disable iff (!sys_nreset)
            tx_active |-> chip_nreset)
            else
            begin
               fail_cnt++;
               $error("tx_active high while chip_nreset is low");
            end

         pll_vs_active: assert property (@(posedge sys_clk) disable iff (!sys_nreset)
            !(pll_reset && tx_active))
            else
            begin
               fail_cnt++;
               $error("pll_reset and tx_active high together");
            end

      end
      else
      begin : g_link

         //##################################################
         // link credits and buffer pops
         //##################################################

         credit_limit: assert property (@(posedge sys_clk) disable iff (!sys_nreset)
            credit_cnt <= LINK_CREDITS)
            else
            begin
               fail_cnt++;
               $error("link credit count above its limit");
            end

         pop_not_empty: assert property (@(posedge sys_clk) disable iff (!sys_nreset)
            rd_pop |-> !rd_empty)
            else
            begin
               fail_cnt++;
               $error("pop from an empty buffer");
            end

      end
   endgenerate

endmodule

// sequencer rules, credit inputs unused
bind etx_reset_seq etx_tb_assertions #(
   .SEQ_CHECKS (1'b1)
) u_seq_assertions (
   .sys_clk     (sys_clk),
   .sys_nreset  (sys_nreset),
   .pll_reset   (pll_reset),
   .chip_nreset (chip_nreset),
   .tx_active   (tx_active),
   .credit_cnt  ('0),
   .rd_pop      (1'b0),
   .rd_empty    (1'b0)
);

// link rules, sequencer inputs unused
bind etx_credit_tx etx_tb_assertions #(
   .LINK_CREDITS (LINK_CREDITS),
   .CW           (CW),
   .SEQ_CHECKS   (1'b0)
) u_tx_assertions (
   .sys_clk     (sys_clk),
   .sys_nreset  (sys_nreset),
   .pll_reset   (1'b0),
   .chip_nreset (1'b1),
   .tx_active   (tx_active),
   .credit_cnt  (credit_cnt),
   .rd_pop      (rd_pop),
   .rd_empty    (rd_empty)
);

`default_nettype wire
